// File: sched_cfg_pkg.sv
// Issue scheduler configuration with ROB sizing, window size and index types
package sched_cfg_pkg;

	// ==================================================
	// sizes
	// ==================================================

	// number of reorder buffer entries
	localparam int ROB_ENTRIES = 8;

	// entries scanned per cycle, starting at the head
	localparam int WINDOW_SIZE = 8;

	localparam int ROB_NDX_W = 3;

	// sequence numbers give program order inside the ROB
	localparam int SN_W = 4;

	// ==================================================
	// types
	// ==================================================

	typedef logic [ROB_NDX_W-1:0] rob_ndx_t;

	// one bit per ROB entry
	typedef logic [ROB_ENTRIES-1:0] rob_mask_t;

endpackage

// File: rob_pkg.sv
// Reorder buffer record layout and op kind encoding seen by the issue scheduler
package rob_pkg;

	import sched_cfg_pkg::*;

	// kind of functional unit that executes an op
	typedef enum logic [1:0] {
		OP_ALU = 2'd0,
		OP_MEM = 2'd1,
		OP_FC  = 2'd2
	} op_kind_t;

	// one ROB entry, eleven bits with v at the top and sync at bit 0
	typedef struct packed {
		// entry holds a live op
		logic            v;
		// program order, smaller is older
		logic [SN_W-1:0] sn;
		op_kind_t        kind;
		// all source operands are available
		logic            args_v;
		// result has been written back
		logic            done;
		// op has been sent to a unit and is executing
		logic            out;
		// sync op, younger entries wait for it to retire
		logic            sync;
	} rob_entry_t;

endpackage

// File: sched_grant_if.sv
// Grant bundle from the issue selector to the issue result registers
`timescale 1ns/100ps

interface sched_grant_if import sched_cfg_pkg::*; ();

	rob_ndx_t  next_alu0_rndx;
	logic      next_alu0_rndxv;
	rob_ndx_t  next_alu1_rndx;
	logic      next_alu1_rndxv;
	rob_ndx_t  next_agen_rndx;
	logic      next_agen_rndxv;
	rob_ndx_t  next_fcu_rndx;
	logic      next_fcu_rndxv;

	// every entry granted to any unit this cycle
	rob_mask_t next_issue_mask;

	modport sel (
		output next_alu0_rndx, next_alu0_rndxv,
		output next_alu1_rndx, next_alu1_rndxv,
		output next_agen_rndx, next_agen_rndxv,
		output next_fcu_rndx, next_fcu_rndxv,
		output next_issue_mask
	);

	modport regs (
		input next_alu0_rndx, next_alu0_rndxv,
		input next_alu1_rndx, next_alu1_rndxv,
		input next_agen_rndx, next_agen_rndxv,
		input next_fcu_rndx, next_fcu_rndxv,
		input next_issue_mask
	);

endinterface

// File: sched_ready.sv
// Issue scheduler decode stage that registers which ROB entries are ready
`timescale 1ns/100ps

module sched_ready import sched_cfg_pkg::*, rob_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  rob_entry_t [ROB_ENTRIES-1:0] rob_i,
	output rob_mask_t                    ready_mask_o
);

	rob_mask_t next_ready;

	// a live sync op older than the entry holds it back until it leaves the ROB
	function automatic logic prior_sync(input rob_ndx_t ndx);
		logic found;
		found = 1'b0;
		for (int n = 0; n < ROB_ENTRIES; n++) begin
			if (rob_i[n].v && rob_i[n].sync && rob_i[n].sn < rob_i[ndx].sn)
				found = 1'b1;
		end
		return found;
	endfunction

	// ==================================================
	// per-entry readiness
	// ==================================================

	always_comb begin
		for (int g = 0; g < ROB_ENTRIES; g++) begin
			next_ready[g] = rob_i[g].v
				&& !rob_i[g].done
				&& !rob_i[g].out
				&& rob_i[g].args_v
				&& !prior_sync(rob_ndx_t'(g));
		end
	end

	// the mask is evaluated once for the whole ROB and registered
	always_ff @(posedge clk) begin
		if (rst)
			ready_mask_o <= '0;
		else
			ready_mask_o <= next_ready;
	end

endmodule

// File: sched_select.sv
// Issue scheduler execute stage that scans the window from the head and picks ops
`timescale 1ns/100ps

module sched_select import sched_cfg_pkg::*, rob_pkg::*; (
	input  rob_entry_t [ROB_ENTRIES-1:0] rob_i,
	input  rob_ndx_t                     head_i,
	input  rob_mask_t                    ready_mask_i,
	input  rob_mask_t                    recent_mask_i,
	input  logic                         alu0_idle_i,
	input  logic                         alu1_idle_i,
	input  logic                         agen_idle_i,
	input  logic                         fcu_idle_i,
	sched_grant_if.sel                   grant
);

	logic fc_in_flight;

	// true when an older live entry of the given kind has not finished
	function automatic logic prior_open(input rob_ndx_t ndx, input op_kind_t kind);
		logic found;
		found = 1'b0;
		for (int n = 0; n < ROB_ENTRIES; n++) begin
			if (rob_i[n].v && !rob_i[n].done && rob_i[n].kind == kind
				&& rob_i[n].sn < rob_i[ndx].sn)
				found = 1'b1;
		end
		return found;
	endfunction

	// flow control runs one op at a time
	always_comb begin
		fc_in_flight = 1'b0;
		for (int n = 0; n < ROB_ENTRIES; n++) begin
			if (rob_i[n].v && rob_i[n].kind == OP_FC && rob_i[n].out)
				fc_in_flight = 1'b1;
		end
	end

	// ==================================================
	// window scan, oldest first
	// ==================================================

	always_comb begin
		rob_ndx_t ndx;
		logic     elig;

		grant.next_alu0_rndx  = '0;
		grant.next_alu0_rndxv = 1'b0;
		grant.next_alu1_rndx  = '0;
		grant.next_alu1_rndxv = 1'b0;
		grant.next_agen_rndx  = '0;
		grant.next_agen_rndxv = 1'b0;
		grant.next_fcu_rndx   = '0;
		grant.next_fcu_rndxv  = 1'b0;
		grant.next_issue_mask = '0;

		for (int hd = 0; hd < WINDOW_SIZE; hd++) begin
			// the index wraps around the ROB since its size is a power of two
			ndx  = head_i + rob_ndx_t'(hd);
			elig = ready_mask_i[ndx] && !recent_mask_i[ndx];
			if (elig) begin
				case (rob_i[ndx].kind)
					OP_ALU: begin
						if (alu0_idle_i && !grant.next_alu0_rndxv) begin
							grant.next_alu0_rndx  = ndx;
							grant.next_alu0_rndxv = 1'b1;
							grant.next_issue_mask[ndx] = 1'b1;
						end
						else if (alu1_idle_i && !grant.next_alu1_rndxv) begin
							grant.next_alu1_rndx  = ndx;
							grant.next_alu1_rndxv = 1'b1;
							grant.next_issue_mask[ndx] = 1'b1;
						end
					end
					// loads and stores leave in program order
					OP_MEM: begin
						if (agen_idle_i && !grant.next_agen_rndxv
							&& !prior_open(ndx, OP_MEM)) begin
							grant.next_agen_rndx  = ndx;
							grant.next_agen_rndxv = 1'b1;
							grant.next_issue_mask[ndx] = 1'b1;
						end
					end
					OP_FC: begin
						if (fcu_idle_i && !grant.next_fcu_rndxv && !fc_in_flight
							&& !prior_open(ndx, OP_FC)) begin
							grant.next_fcu_rndx  = ndx;
							grant.next_fcu_rndxv = 1'b1;
							grant.next_issue_mask[ndx] = 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// each granted entry belongs to exactly one unit
	always_comb begin
		assert final ($countones(grant.next_issue_mask) == $countones({grant.next_alu0_rndxv,
			grant.next_alu1_rndxv, grant.next_agen_rndxv, grant.next_fcu_rndxv}))
		else
			$error("entry granted to more than one unit");
	end

endmodule

// File: sched_issue_reg.sv
// Issue scheduler result stage that registers grants and tracks recent issues
`timescale 1ns/100ps

module sched_issue_reg import sched_cfg_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	sched_grant_if.regs  grant,
	output rob_mask_t    recent_mask_o,
	output rob_ndx_t     alu0_rndx_o,
	output logic         alu0_rndxv_o,
	output rob_ndx_t     alu1_rndx_o,
	output logic         alu1_rndxv_o,
	output rob_ndx_t     agen_rndx_o,
	output logic         agen_rndxv_o,
	output rob_ndx_t     fcu_rndx_o,
	output logic         fcu_rndxv_o
);

	// grants from one and two cycles ago
	rob_mask_t issue_d1;
	rob_mask_t issue_d2;

	always_ff @(posedge clk) begin
		if (rst) begin
			alu0_rndxv_o <= 1'b0;
			alu1_rndxv_o <= 1'b0;
			agen_rndxv_o <= 1'b0;
			fcu_rndxv_o  <= 1'b0;
			issue_d1     <= '0;
			issue_d2     <= '0;
		end
		else begin
			alu0_rndxv_o <= grant.next_alu0_rndxv;
			alu1_rndxv_o <= grant.next_alu1_rndxv;
			agen_rndxv_o <= grant.next_agen_rndxv;
			fcu_rndxv_o  <= grant.next_fcu_rndxv;
			issue_d1     <= grant.next_issue_mask;
			issue_d2     <= issue_d1;
		end
	end

	always_ff @(posedge clk) begin
		alu0_rndx_o <= grant.next_alu0_rndx;
		alu1_rndx_o <= grant.next_alu1_rndx;
		agen_rndx_o <= grant.next_agen_rndx;
		fcu_rndx_o  <= grant.next_fcu_rndx;
	end

	// an issued entry sits out two cycles while its out flag reaches the ROB
	assign recent_mask_o = issue_d1 | issue_d2;

	// ==================================================
	// checks
	// ==================================================

	a_alu_distinct: assert property (@(posedge clk) disable iff (rst)
		(alu0_rndxv_o && alu1_rndxv_o) |-> (alu0_rndx_o != alu1_rndx_o))
	else
		$error("both ALUs issued the same ROB entry");

endmodule

// File: sched_top.sv
// Issue scheduler top level joining the decode, execute and result stages
`timescale 1ns/100ps

module sched_top import sched_cfg_pkg::*, rob_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  rob_entry_t [ROB_ENTRIES-1:0] rob_i,
	input  rob_ndx_t                     head_i,
	input  logic                         alu0_idle_i,
	input  logic                         alu1_idle_i,
	input  logic                         agen_idle_i,
	input  logic                         fcu_idle_i,
	output rob_ndx_t                     alu0_rndx_o,
	output logic                         alu0_rndxv_o,
	output rob_ndx_t                     alu1_rndx_o,
	output logic                         alu1_rndxv_o,
	output rob_ndx_t                     agen_rndx_o,
	output logic                         agen_rndxv_o,
	output rob_ndx_t                     fcu_rndx_o,
	output logic                         fcu_rndxv_o
);

	rob_mask_t ready_mask;
	rob_mask_t recent_mask;

	sched_grant_if grant_if ();

	sched_ready sched_ready_i (
		.clk          (clk),
		.rst          (rst),
		.rob_i        (rob_i),
		.ready_mask_o (ready_mask)
	);

	sched_select sched_select_i (
		.rob_i         (rob_i),
		.head_i        (head_i),
		.ready_mask_i  (ready_mask),
		.recent_mask_i (recent_mask),
		.alu0_idle_i   (alu0_idle_i),
		.alu1_idle_i   (alu1_idle_i),
		.agen_idle_i   (agen_idle_i),
		.fcu_idle_i    (fcu_idle_i),
		.grant         (grant_if.sel)
	);

	sched_issue_reg sched_issue_reg_i (
		.clk           (clk),
		.rst           (rst),
		.grant         (grant_if.regs),
		.recent_mask_o (recent_mask),
		.alu0_rndx_o   (alu0_rndx_o),
		.alu0_rndxv_o  (alu0_rndxv_o),
		.alu1_rndx_o   (alu1_rndx_o),
		.alu1_rndxv_o  (alu1_rndxv_o),
		.agen_rndx_o   (agen_rndx_o),
		.agen_rndxv_o  (agen_rndxv_o),
		.fcu_rndx_o    (fcu_rndx_o),
		.fcu_rndxv_o   (fcu_rndxv_o)
	);

endmodule

// File: tb_sched_checker.sv
// Testbench checker that samples the scheduler grant outputs and compares them
`timescale 1ns/100ps

module tb_sched_checker import sched_cfg_pkg::*; (
	input  logic           clk,
	input  int             req_count_i,
	input  int             vec_num_i,
	input  rob_ndx_t [3:0] exp_ndx_i,
	input  logic [3:0]     exp_v_i,
	input  rob_ndx_t [3:0] act_ndx_i,
	input  logic [3:0]     act_v_i,
	output int             done_count_o,
	output int             error_count_o
);

	function automatic string unit_name(input int u);
		case (u)
			0: return "alu0";
			1: return "alu1";
			2: return "agen";
			default: return "fcu";
		endcase
	endfunction

	task automatic show_mismatch(input string sig, input logic [3:0] exp, input logic [3:0] act);
		$display("** Error vector %0d: %s expected %h got %h", vec_num_i, sig, exp, act);
		error_count_o++;
	endtask

	initial begin
		done_count_o  = 0;
		error_count_o = 0;
	end

	// sampled on the falling edge while the registered grants are stable
	always @(negedge clk) begin
		if (req_count_i != done_count_o) begin
			for (int u = 0; u < 4; u++) begin
				if (act_v_i[u] !== exp_v_i[u])
					show_mismatch({unit_name(u), "_rndxv_o"}, exp_v_i[u], act_v_i[u]);
				// the index only means something while its valid is high
				else if (exp_v_i[u] && act_ndx_i[u] !== exp_ndx_i[u])
					show_mismatch({unit_name(u), "_rndx_o"}, exp_ndx_i[u], act_ndx_i[u]);
			end
			done_count_o++;
		end
	end

endmodule

// File: tb_sched.sv
// Testbench for the issue scheduler that plays ROB snapshots from a vector file
`timescale 1ns/100ps

module tb_sched import sched_cfg_pkg::*, rob_pkg::*; ();

	// fields per vector line are eight entries, head, four idle flags and eight expected values
	localparam int NUM_FIELDS  = 21;
	localparam int MAX_VECTORS = 32;
	localparam int ACK_TIMEOUT = 8;

	logic                         clk;
	logic                         rst;
	rob_entry_t [ROB_ENTRIES-1:0] rob;
	rob_ndx_t                     head;
	logic                         alu0_idle, alu1_idle, agen_idle, fcu_idle;
	rob_ndx_t                     alu0_rndx, alu1_rndx, agen_rndx, fcu_rndx;
	logic                         alu0_rndxv, alu1_rndxv, agen_rndxv, fcu_rndxv;

	// unit order is alu0 alu1 agen fcu from bit 0 upwards
	rob_ndx_t [3:0] exp_ndx;
	logic [3:0]     exp_v;
	rob_ndx_t [3:0] act_ndx;
	logic [3:0]     act_v;

	logic [11:0] vec_mem [0:MAX_VECTORS*NUM_FIELDS-1];
	int          req_count;
	int          done_count;
	int          error_count;
	int          fail_count;
	int          num_vectors;
	int          vec_num;

	assign act_ndx = {fcu_rndx, agen_rndx, alu1_rndx, alu0_rndx};
	assign act_v   = {fcu_rndxv, agen_rndxv, alu1_rndxv, alu0_rndxv};

	sched_top sched_top_i (
		.clk          (clk),
		.rst          (rst),
		.rob_i        (rob),
		.head_i       (head),
		.alu0_idle_i  (alu0_idle),
		.alu1_idle_i  (alu1_idle),
		.agen_idle_i  (agen_idle),
		.fcu_idle_i   (fcu_idle),
		.alu0_rndx_o  (alu0_rndx),
		.alu0_rndxv_o (alu0_rndxv),
		.alu1_rndx_o  (alu1_rndx),
		.alu1_rndxv_o (alu1_rndxv),
		.agen_rndx_o  (agen_rndx),
		.agen_rndxv_o (agen_rndxv),
		.fcu_rndx_o   (fcu_rndx),
		.fcu_rndxv_o  (fcu_rndxv)
	);

	tb_sched_checker checker_i (
		.clk           (clk),
		.req_count_i   (req_count),
		.vec_num_i     (vec_num),
		.exp_ndx_i     (exp_ndx),
		.exp_v_i       (exp_v),
		.act_ndx_i     (act_ndx),
		.act_v_i       (act_v),
		.done_count_o  (done_count),
		.error_count_o (error_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==================================================
	// stimulus
	// ==================================================

	task automatic apply_vector(input int v);
		int base;
		base = v * NUM_FIELDS;
		@(posedge clk);
		#1;
		for (int n = 0; n < ROB_ENTRIES; n++)
			rob[n] = vec_mem[base + n][10:0];
		head      = vec_mem[base + 8][ROB_NDX_W-1:0];
		alu0_idle = vec_mem[base + 9][0];
		alu1_idle = vec_mem[base + 10][0];
		agen_idle = vec_mem[base + 11][0];
		fcu_idle  = vec_mem[base + 12][0];
		for (int u = 0; u < 4; u++) begin
			exp_ndx[u] = vec_mem[base + 13 + 2*u][ROB_NDX_W-1:0];
			exp_v[u]   = vec_mem[base + 14 + 2*u][0];
		end
	endtask

	// grants for the held snapshot appear after the second edge
	task automatic request_check(input int v);
		int waited;
		repeat (2) @(posedge clk);
		#1;
		vec_num = v;
		req_count++;
		waited = 0;
		while (done_count != req_count && waited < ACK_TIMEOUT) begin
			@(negedge clk);
			#1;
			waited++;
		end
		if (done_count != req_count) begin
			$display("checker did not sample vector %0d within %0d cycles", v, ACK_TIMEOUT);
			fail_count++;
		end
	endtask

	// three empty cycles let the hold-off mask drain before the next snapshot
	task automatic flush_rob();
		@(posedge clk);
		#1;
		rob       = '0;
		head      = '0;
		alu0_idle = 1'b1;
		alu1_idle = 1'b1;
		agen_idle = 1'b1;
		fcu_idle  = 1'b1;
		repeat (2) @(posedge clk);
	endtask

	initial begin
		rst         = 1'b1;
		rob         = '0;
		head        = '0;
		alu0_idle   = 1'b1;
		alu1_idle   = 1'b1;
		agen_idle   = 1'b1;
		fcu_idle    = 1'b1;
		exp_ndx     = '0;
		exp_v       = '0;
		req_count   = 0;
		vec_num     = 0;
		fail_count  = 0;
		num_vectors = 0;
		$readmemh("sched_tests.txt", vec_mem);
		while (num_vectors < MAX_VECTORS && !$isunknown(vec_mem[num_vectors*NUM_FIELDS]))
			num_vectors++;
		if (num_vectors == 0) begin
			$display("no test vectors could be read from sched_tests.txt");
			fail_count++;
		end
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;
		for (int v = 0; v < num_vectors && fail_count == 0; v++) begin
			apply_vector(v);
			request_check(v);
			flush_rob();
		end
		$display("vectors checked %0d, mismatches %0d, other failures %0d",
			done_count, error_count, fail_count);
		if (fail_count == 0 && error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: sched_tests.txt
// each line holds rob entries 0 to 7 then head and the alu0 alu1 agen fcu idle flags
// followed by expected index and valid for alu0 alu1 agen and fcu
// empty ROB after reset
000 000 000 000 000 000 000 000 0 1 1 1 1 0 0 0 0 0 0 0 0
// oldest first with the window wrapping past entry 7
488 000 000 000 000 000 408 448 6 1 1 1 1 6 1 7 1 0 0 0 0
// older sync op holds younger ops back
401 448 000 000 000 000 000 000 0 1 1 1 1 0 0 0 0 0 0 0 0
000 448 000 000 000 000 000 000 0 1 1 1 1 1 1 0 0 0 0 0 0
408 441 488 000 000 000 000 000 0 1 1 1 1 0 1 0 0 0 0 0 0
// memory ops in program order
558 000 000 498 000 000 000 000 0 1 1 1 1 0 0 0 0 3 1 0 0
410 458 000 000 000 000 000 000 0 1 1 1 1 0 0 0 0 0 0 0 0
41C 458 000 000 000 000 000 000 0 1 1 1 1 0 0 0 0 1 1 0 0
// one flow control op at a time
56A 468 488 000 000 000 000 000 0 1 1 1 1 2 1 0 0 0 0 0 0
428 468 000 000 000 000 000 000 0 1 1 1 1 0 0 0 0 0 0 0 1
420 468 000 000 000 000 000 000 0 1 1 1 1 0 0 0 0 0 0 0 0
42C 468 000 000 000 000 000 000 0 1 1 1 1 0 0 0 0 0 0 1 1
// busy units get nothing
408 448 488 000 000 000 000 000 0 1 0 1 1 0 1 0 0 0 0 0 0
408 448 488 000 000 000 000 000 0 0 1 1 1 0 0 0 1 0 0 0 0
418 468 488 000 000 000 000 000 0 1 1 0 1 2 1 0 0 0 0 1 1
418 468 488 000 000 000 000 000 0 1 1 1 0 2 1 0 0 0 1 0 0
// all four units granted in one cycle
4C8 508 000 000 000 408 458 4A8 5 1 1 1 1 5 1 0 1 6 1 7 1
000 000 000 000 000 000 000 000 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: project.f
sched_cfg_pkg.sv
rob_pkg.sv
sched_grant_if.sv
sched_ready.sv
sched_select.sv
sched_issue_reg.sv
sched_top.sv
tb_sched_checker.sv
tb_sched.sv
